// ==== logic/eye_cfg.svh ====
`ifndef EYE_CFG_SVH
`define EYE_CFG_SVH

// Pixel sample width, one lane
`define EYE_PIXEL_W     8

// Column and row counters, enough for 640 x 480
`define EYE_COORD_W     10

// Object pixel count over a full frame
`define EYE_COUNT_W     20

// Coordinate sums, 640 * 480 pixels at coordinate 1023 still fit
`define EYE_SUM_W       29

// Frame tag carried with each result, wraps
`define EYE_FRAME_ID_W  8

`endif

// ==== logic/eye_pkg.sv ====
`include "eye_cfg.svh"

package eye_pkg;

    // One classified pixel or frame edge from the camera front end
    typedef struct packed {
        logic                    frame_start;
        logic                    frame_end;
        logic                    pix_valid;
        logic                    object;
        logic [`EYE_COORD_W-1:0] x;
        logic [`EYE_COORD_W-1:0] y;
    } pixel_evt_t;

    // Totals of one frame
    typedef struct packed {
        logic [`EYE_FRAME_ID_W-1:0] frame_id;
        logic [`EYE_COUNT_W-1:0]    count;
        logic [`EYE_SUM_W-1:0]      sum_x;
        logic [`EYE_SUM_W-1:0]      sum_y;
    } moment_t;

    // Centroid result, empty when no object pixel was seen
    typedef struct packed {
        logic [`EYE_FRAME_ID_W-1:0] frame_id;
        logic                       empty;
        logic [`EYE_COORD_W-1:0]    cx;
        logic [`EYE_COORD_W-1:0]    cy;
        logic [`EYE_COUNT_W-1:0]    count;
    } centroid_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

endpackage

// ==== logic/camera_input.sv ====
`include "eye_cfg.svh"

module camera_input
    import eye_pkg::*;
(
    input  logic                    cclk,
    input  logic                    reset,
    input  logic                    fval,
    input  logic                    lval,
    input  logic                    dval,
    input  logic [`EYE_PIXEL_W-1:0] pixel,
    input  logic [`EYE_PIXEL_W-1:0] threshold,
    output pixel_evt_t              evt
);

    // Input register stage
    logic                    fval_q;
    logic                    lval_q;
    logic                    dval_q;
    logic [`EYE_PIXEL_W-1:0] pixel_q;

    // Previous samples for edge detection
    logic                    fval_d;
    logic                    lval_d;

    logic [`EYE_COORD_W-1:0] col;
    logic [`EYE_COORD_W-1:0] row;
    logic [`EYE_COORD_W-1:0] col_cur;
    logic [`EYE_COORD_W-1:0] row_cur;

    logic                    frame_rise;
    logic                    frame_fall;
    logic                    line_fall;
    logic                    pix_ok;

    always_ff @(posedge cclk) begin
        if (reset) begin
            fval_q <= 1'b0;
            lval_q <= 1'b0;
            dval_q <= 1'b0;
        end else begin
            fval_q <= fval;
            lval_q <= lval;
            dval_q <= dval;
        end
    end

    always_ff @(posedge cclk) begin
        pixel_q <= pixel;
    end

    assign frame_rise = fval_q & ~fval_d;
    assign frame_fall = ~fval_q & fval_d;
    assign line_fall  = ~lval_q & lval_d;
    assign pix_ok     = fval_q & lval_q & dval_q;

    // First pixel may arrive together with the frame edge
    assign col_cur = frame_rise ? '0 : col;
    assign row_cur = frame_rise ? '0 : row;

    // Classify stage
    always_ff @(posedge cclk) begin
        if (reset) begin
            fval_d <= 1'b0;
            lval_d <= 1'b0;
            col    <= '0;
            row    <= '0;
            evt    <= '0;
        end else begin
            fval_d          <= fval_q;
            lval_d          <= lval_q;
            evt.frame_start <= frame_rise;
            evt.frame_end   <= frame_fall;
            evt.pix_valid   <= pix_ok;
            evt.object      <= pix_ok && (pixel_q >= threshold);
            evt.x           <= col_cur;
            evt.y           <= row_cur;

            if (pix_ok) begin
                col <= col_cur + 1'b1;
            end else if (line_fall) begin
                col <= '0;
            end else begin
                col <= col_cur;
            end

            if (frame_rise) begin
                row <= '0;
            end else if (line_fall) begin
                row <= row + 1'b1;
            end
        end
    end

endmodule

// ==== logic/moment_accum.sv ====
`include "eye_cfg.svh"

module moment_accum
    import eye_pkg::*;
(
    input  logic       cclk,
    input  logic       reset,
    input  pixel_evt_t evt,
    input  logic       totals_ready,
    output moment_t    totals,
    output logic       totals_valid,
    output logic       overrun
);

    logic [`EYE_COUNT_W-1:0]    run_count;
    logic [`EYE_SUM_W-1:0]      run_sx;
    logic [`EYE_SUM_W-1:0]      run_sy;
    logic [`EYE_COUNT_W-1:0]    base_count;
    logic [`EYE_SUM_W-1:0]      base_sx;
    logic [`EYE_SUM_W-1:0]      base_sy;
    logic [`EYE_FRAME_ID_W-1:0] frame_id;
    logic                       add;
    logic                       slot_busy;

    // ------------------------------------------------------------------------
    // Running moments of the current frame
    // ------------------------------------------------------------------------

    assign add = evt.pix_valid & evt.object;

    // Clear at frame start without losing a pixel on the same cycle
    assign base_count = evt.frame_start ? '0 : run_count;
    assign base_sx    = evt.frame_start ? '0 : run_sx;
    assign base_sy    = evt.frame_start ? '0 : run_sy;

    always_ff @(posedge cclk) begin
        if (reset) begin
            run_count <= '0;
            run_sx    <= '0;
            run_sy    <= '0;
        end else begin
            run_count <= base_count + `EYE_COUNT_W'(add);
            run_sx    <= base_sx + (add ? `EYE_SUM_W'(evt.x) : '0);
            run_sy    <= base_sy + (add ? `EYE_SUM_W'(evt.y) : '0);
        end
    end

    // ------------------------------------------------------------------------
    // Hand-off register towards the divider
    // ------------------------------------------------------------------------

    // Slot frees up if the divider takes it on this very cycle
    assign slot_busy = totals_valid & ~totals_ready;

    always_ff @(posedge cclk) begin
        if (reset) begin
            totals_valid <= 1'b0;
            overrun      <= 1'b0;
            frame_id     <= '0;
        end else begin
            overrun <= evt.frame_end & slot_busy;

            if (totals_valid && totals_ready) begin
                totals_valid <= 1'b0;
            end

            if (evt.frame_end) begin
                frame_id <= frame_id + 1'b1;
                if (!slot_busy) begin
                    totals_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge cclk) begin
        if (evt.frame_end && !slot_busy) begin
            totals.frame_id <= frame_id;
            totals.count    <= run_count;
            totals.sum_x    <= run_sx;
            totals.sum_y    <= run_sy;
        end
    end

endmodule

// ==== logic/centroid_divider.sv ====
`include "eye_cfg.svh"

module centroid_divider
    import eye_pkg::*;
(
    input  logic      cclk,
    input  logic      reset,
    input  moment_t   totals,
    input  logic      totals_valid,
    output logic      totals_ready,
    input  logic      result_ready,
    output centroid_t result,
    output logic      result_valid
);

    localparam int STEP_W = `EYE_COUNT_W + `EYE_SUM_W;
    localparam int CNT_W  = $clog2(`EYE_SUM_W);

    div_state_e                 state;
    logic [CNT_W-1:0]           step_cnt;
    logic                       accept;
    logic                       zero_count;

    logic [`EYE_FRAME_ID_W-1:0] frame_id;
    logic [`EYE_COUNT_W-1:0]    den;
    // Dividend, quotient bits shift in from the bottom
    logic [`EYE_SUM_W-1:0]      num_x;
    logic [`EYE_SUM_W-1:0]      num_y;
    logic [`EYE_COUNT_W-1:0]    rem_x;
    logic [`EYE_COUNT_W-1:0]    rem_y;
    logic [STEP_W-1:0]          next_x;
    logic [STEP_W-1:0]          next_y;

    // One restoring step, returns {remainder, dividend/quotient}
    function automatic logic [STEP_W-1:0] div_step(
        input logic [`EYE_COUNT_W-1:0] rem,
        input logic [`EYE_SUM_W-1:0]   num,
        input logic [`EYE_COUNT_W-1:0] dvs
    );
        logic [`EYE_COUNT_W:0] part;
        logic [`EYE_COUNT_W:0] diff;
        part = {rem, num[`EYE_SUM_W-1]};
        diff = part - {1'b0, dvs};
        if (part >= {1'b0, dvs}) begin
            return {diff[`EYE_COUNT_W-1:0], num[`EYE_SUM_W-2:0], 1'b1};
        end
        return {part[`EYE_COUNT_W-1:0], num[`EYE_SUM_W-2:0], 1'b0};
    endfunction

    assign totals_ready = (state == DIV_IDLE);
    assign result_valid = (state == DIV_DONE);
    assign accept       = totals_valid & totals_ready;
    assign zero_count   = (totals.count == '0);

    assign next_x = div_step(rem_x, num_x, den);
    assign next_y = div_step(rem_y, num_y, den);

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge cclk) begin
        if (reset) begin
            state    <= DIV_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (totals_valid) begin
                        step_cnt <= CNT_W'(`EYE_SUM_W - 1);
                        state    <= zero_count ? DIV_DONE : DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    step_cnt <= step_cnt - 1'b1;
                    if (step_cnt == '0) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    // Hold the result until the sink takes it
                    if (result_ready) begin
                        state <= DIV_IDLE;
                    end
                end
                default: begin
                    state <= DIV_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Datapath, x and y run side by side
    // ------------------------------------------------------------------------

    always_ff @(posedge cclk) begin
        if (accept) begin
            frame_id <= totals.frame_id;
            den      <= totals.count;
            rem_x    <= '0;
            rem_y    <= '0;
            num_x    <= zero_count ? '0 : totals.sum_x;
            num_y    <= zero_count ? '0 : totals.sum_y;
        end else if (state == DIV_RUN) begin
            {rem_x, num_x} <= next_x;
            {rem_y, num_y} <= next_y;
        end
    end

    always_comb begin
        result.frame_id = frame_id;
        result.empty    = (den == '0);
        result.cx       = num_x[`EYE_COORD_W-1:0];
        result.cy       = num_y[`EYE_COORD_W-1:0];
        result.count    = den;
    end

endmodule

// ==== logic/eye_tracker_top.sv ====
`include "eye_cfg.svh"

module eye_tracker_top
    import eye_pkg::*;
(
    input  logic                    cclk,
    input  logic                    reset,
    input  logic                    fval,
    input  logic                    lval,
    input  logic                    dval,
    input  logic [`EYE_PIXEL_W-1:0] pixel,
    input  logic [`EYE_PIXEL_W-1:0] threshold,
    output centroid_t               result,
    output logic                    result_valid,
    input  logic                    result_ready,
    output logic                    overrun
);

    pixel_evt_t evt;
    moment_t    totals;
    logic       totals_valid;
    logic       totals_ready;

    // Camera front end, two cycles from pin to event
    camera_input u_camera_input (
        .cclk      (cclk),
        .reset     (reset),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .pixel     (pixel),
        .threshold (threshold),
        .evt       (evt)
    );

    moment_accum u_moment_accum (
        .cclk         (cclk),
        .reset        (reset),
        .evt          (evt),
        .totals_ready (totals_ready),
        .totals       (totals),
        .totals_valid (totals_valid),
        .overrun      (overrun)
    );

    centroid_divider u_centroid_divider (
        .cclk         (cclk),
        .reset        (reset),
        .totals       (totals),
        .totals_valid (totals_valid),
        .totals_ready (totals_ready),
        .result_ready (result_ready),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
    output logic cclk,
    output logic reset
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 16;

    initial begin
        cclk = 1'b0;
        forever #HALF_PERIOD cclk = ~cclk;
    end

    // Reset drops on a falling edge after 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge cclk);
        reset = 1'b0;
    end

endmodule

// ==== bench/tb_checker.sv ====
`include "eye_cfg.svh"

module tb_checker
    import eye_pkg::*;
(
    input  logic                    cclk,
    input  logic                    reset,
    input  logic                    fval,
    input  logic                    lval,
    input  logic                    dval,
    input  logic [`EYE_PIXEL_W-1:0] pixel,
    input  logic [`EYE_PIXEL_W-1:0] threshold,
    input  centroid_t               result,
    input  logic                    result_valid,
    input  logic                    result_ready,
    input  logic                    overrun,
    output int                      error_count,
    output int                      frames_ended,
    output int                      results_seen,
    output int                      overruns_seen,
    output logic                    settled
);

    localparam int MAX_PIX = 1024;
    localparam int ID_NUM  = 1 << `EYE_FRAME_ID_W;

    // Frame id status
    localparam int ST_NONE     = 0;
    localparam int ST_PENDING  = 1;
    localparam int ST_REPORTED = 2;
    localparam int ST_OVERRUN  = 3;

    logic [`EYE_PIXEL_W-1:0]    pix_val [MAX_PIX];
    int                         pix_x   [MAX_PIX];
    int                         pix_y   [MAX_PIX];
    int                         n_pix;
    int                         col;
    int                         row;
    logic [`EYE_PIXEL_W-1:0]    frame_thr;
    logic                       fval_prev;
    logic                       lval_prev;
    logic [`EYE_FRAME_ID_W-1:0] next_id;
    logic [`EYE_FRAME_ID_W-1:0] last_end_id;
    logic [`EYE_FRAME_ID_W-1:0] rid;
    centroid_t                  expected [ID_NUM];
    int                         id_state [ID_NUM];
    int                         last_result_id;
    logic                       hold_active;
    centroid_t                  held;

    // Floor of coordinate sums over object pixel count
    function automatic centroid_t expected_centroid(
        input int                         n,
        input logic [`EYE_PIXEL_W-1:0]    thr,
        input logic [`EYE_FRAME_ID_W-1:0] id
    );
        centroid_t r;
        int        cnt;
        longint    sx;
        longint    sy;
        cnt = 0;
        sx  = 0;
        sy  = 0;
        for (int i = 0; i < n; i++) begin
            if (pix_val[i] >= thr) begin
                cnt++;
                sx += pix_x[i];
                sy += pix_y[i];
            end
        end
        r.frame_id = id;
        r.empty    = (cnt == 0);
        r.count    = `EYE_COUNT_W'(cnt);
        r.cx       = (cnt == 0) ? '0 : `EYE_COORD_W'(sx / cnt);
        r.cy       = (cnt == 0) ? '0 : `EYE_COORD_W'(sy / cnt);
        return r;
    endfunction

    assign settled = (results_seen + overruns_seen == frames_ended) && !result_valid;

    // ------------------------------------------------------------------------
    // Frame capture from the camera pins
    // ------------------------------------------------------------------------

    always @(posedge cclk) begin
        if (reset) begin
            n_pix       = 0;
            col         = 0;
            row         = 0;
            frame_thr   = '0;
            fval_prev   = 1'b0;
            lval_prev   = 1'b0;
            next_id     = '0;
            last_end_id = '0;
            frames_ended = 0;
            for (int i = 0; i < ID_NUM; i++) begin
                id_state[i] = ST_NONE;
            end
        end else begin
            if (fval && !fval_prev) begin
                n_pix     = 0;
                col       = 0;
                row       = 0;
                frame_thr = threshold;
            end
            if (fval && lval && dval && n_pix < MAX_PIX) begin
                pix_val[n_pix] = pixel;
                pix_x[n_pix]   = col;
                pix_y[n_pix]   = row;
                n_pix++;
                col++;
            end
            if (lval_prev && !lval) begin
                col = 0;
                row++;
            end
            if (!fval && fval_prev) begin
                expected[next_id] = expected_centroid(n_pix, frame_thr, next_id);
                id_state[next_id] = ST_PENDING;
                last_end_id       = next_id;
                next_id           = next_id + 1'b1;
                frames_ended++;
            end
            fval_prev = fval;
            lval_prev = lval;
        end
    end

    // ------------------------------------------------------------------------
    // Result and overrun comparison
    // ------------------------------------------------------------------------

    always @(posedge cclk) begin
        if (reset) begin
            error_count    = 0;
            results_seen   = 0;
            overruns_seen  = 0;
            last_result_id = -1;
            hold_active    = 1'b0;
            held           = '0;
        end else begin
            if (hold_active && !result_valid) begin
                $display("Error at %0t: result_valid dropped before transfer", $time);
                error_count++;
            end else if (hold_active && result !== held) begin
                $display("Error at %0t: result changed while stalled", $time);
                error_count++;
            end
            if (result_valid && result_ready) begin
                rid = result.frame_id;
                results_seen++;
                if (id_state[rid] != ST_PENDING) begin
                    $display("Error at %0t: result for frame %0d not pending, state %0d",
                             $time, rid, id_state[rid]);
                    error_count++;
                end else if (result !== expected[rid]) begin
                    // Fields shown as count, cx, cy, empty
                    $display("Error at %0t: frame %0d got %0d %0d %0d %0b, expected %0d %0d %0d %0b",
                             $time, rid, result.count, result.cx, result.cy, result.empty,
                             expected[rid].count, expected[rid].cx, expected[rid].cy,
                             expected[rid].empty);
                    error_count++;
                end
                if (int'(rid) <= last_result_id) begin
                    $display("Error at %0t: frame %0d out of order", $time, rid);
                    error_count++;
                end
                id_state[rid]  = ST_REPORTED;
                last_result_id = int'(rid);
            end
            // Overrun belongs to the frame that ended last
            if (overrun) begin
                overruns_seen++;
                if (id_state[last_end_id] != ST_PENDING) begin
                    $display("Error at %0t: overrun for frame %0d in state %0d",
                             $time, last_end_id, id_state[last_end_id]);
                    error_count++;
                end
                id_state[last_end_id] = ST_OVERRUN;
            end
            hold_active = result_valid && !result_ready;
            held        = result;
        end
    end

endmodule

// ==== bench/tb_top.sv ====
`include "eye_cfg.svh"

module tb_top
    import eye_pkg::*;
();

    localparam int NUM_FRAMES     = 14;
    localparam int LINE_MAX       = 2 * 24 + 10;
    localparam int FRAME_MAX      = 5 + 16 * LINE_MAX + 20;
    localparam int TIMEOUT_CYCLES = 16 + NUM_FRAMES * FRAME_MAX + 500;

    logic                    cclk;
    logic                    reset;
    logic                    fval;
    logic                    lval;
    logic                    dval;
    logic [`EYE_PIXEL_W-1:0] pixel;
    logic [`EYE_PIXEL_W-1:0] threshold;
    logic                    result_ready;
    centroid_t               result;
    logic                    result_valid;
    logic                    overrun;
    int                      error_count;
    int                      frames_ended;
    int                      results_seen;
    int                      overruns_seen;
    logic                    settled;
    logic [31:0]             lfsr;
    logic                    hold_ready;
    logic                    drain;
    int                      end_errors;
    int                      cycle_count = 0;

    tb_clock u_tb_clock (
        .cclk  (cclk),
        .reset (reset)
    );

    eye_tracker_top u_eye_tracker_top (
        .cclk         (cclk),
        .reset        (reset),
        .fval         (fval),
        .lval         (lval),
        .dval         (dval),
        .pixel        (pixel),
        .threshold    (threshold),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .overrun      (overrun)
    );

    tb_checker u_tb_checker (
        .cclk          (cclk),
        .reset         (reset),
        .fval          (fval),
        .lval          (lval),
        .dval          (dval),
        .pixel         (pixel),
        .threshold     (threshold),
        .result        (result),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .overrun       (overrun),
        .error_count   (error_count),
        .frames_ended  (frames_ended),
        .results_seen  (results_seen),
        .overruns_seen (overruns_seen),
        .settled       (settled)
    );

    // ------------------------------------------------------------------------
    // Random source and stimulus helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Dark blob on a bright background
    function automatic logic [7:0] pixel_value(
        input int xx,
        input int yy,
        input int bx,
        input int by,
        input int kind
    );
        logic in_blob;
        in_blob = (xx - bx <= 3) && (bx - xx <= 3) && (yy - by <= 2) && (by - yy <= 2);
        if (kind == 2 || in_blob) begin
            return 8'(rand_bits(7));
        end
        return 8'h80 | 8'(rand_bits(7));
    endfunction

    task automatic drive_cycle(
        input logic       fv,
        input logic       lv,
        input logic       dv,
        input logic [7:0] px
    );
        @(negedge cclk);
        fval  = fv;
        lval  = lv;
        dval  = dv;
        pixel = px;
        if (hold_ready) begin
            result_ready = 1'b0;
        end else if (drain) begin
            result_ready = 1'b1;
        end else begin
            result_ready = (rand_bits(2) != 32'd0);
        end
    endtask

    // Frame blanking, threshold changes only here
    task automatic frame_gap(input logic [7:0] thr);
        int blank;
        blank = 4 + int'(rand_bits(4));
        drive_cycle(1'b0, 1'b0, 1'(rand_bits(1)), 8'(rand_bits(8)));
        threshold = thr;
        repeat (blank) begin
            drive_cycle(1'b0, 1'b0, 1'(rand_bits(1)), 8'(rand_bits(8)));
        end
    endtask

    task automatic send_frame(input int w, input int h, input int kind);
        int         bx;
        int         by;
        int         blank;
        logic [7:0] px;
        bx    = int'(rand_bits(5)) % w;
        by    = int'(rand_bits(4)) % h;
        blank = 1 + int'(rand_bits(2));
        repeat (blank) begin
            drive_cycle(1'b1, 1'b0, 1'(rand_bits(1)), 8'(rand_bits(8)));
        end
        for (int yy = 0; yy < h; yy++) begin
            for (int xx = 0; xx < w; xx++) begin
                // dval gap with junk on the pixel bus
                if (rand_bits(2) == 32'd0) begin
                    drive_cycle(1'b1, 1'b1, 1'b0, 8'(rand_bits(8)));
                end
                px = pixel_value(xx, yy, bx, by, kind);
                drive_cycle(1'b1, 1'b1, 1'b1, px);
            end
            blank = 2 + int'(rand_bits(3));
            repeat (blank) begin
                drive_cycle(1'b1, 1'b0, 1'(rand_bits(1)), 8'(rand_bits(8)));
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        int         w;
        int         h;
        int         kind;
        logic [7:0] thr;
        fval         = 1'b0;
        lval         = 1'b0;
        dval         = 1'b0;
        pixel        = '0;
        threshold    = 8'h80;
        result_ready = 1'b0;
        lfsr         = 32'hfb4174ea;
        hold_ready   = 1'b0;
        drain        = 1'b0;
        end_errors   = 0;
        thr          = 8'h80;
        @(negedge reset);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            w    = 24;
            h    = 16;
            kind = 0;
            case (f)
                0: begin
                    kind = 1;
                    thr  = 8'h00;
                end
                1: begin
                    kind = 2;
                    thr  = 8'h80;
                end
                5, 10, 13: begin
                    w   = 4 + int'(rand_bits(3));
                    h   = 3 + int'(rand_bits(2));
                    thr = 8'h40 | 8'(rand_bits(6));
                end
                default: begin
                    thr = 8'h40 | 8'(rand_bits(6));
                end
            endcase
            // Sink stalls across four frame ends
            hold_ready = (f >= 6) && (f <= 9);
            frame_gap(thr);
            send_frame(w, h, kind);
        end
        hold_ready = 1'b0;
        frame_gap(thr);
        drain = 1'b1;
        while (!settled) begin
            drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
        end
        repeat (8) begin
            drive_cycle(1'b0, 1'b0, 1'b0, 8'h00);
        end
        if (results_seen + overruns_seen != NUM_FRAMES) begin
            $display("Got %0d results and overruns for %0d frames",
                     results_seen + overruns_seen, NUM_FRAMES);
            end_errors++;
        end
        if (overruns_seen == 0) begin
            $display("No overrun happened during the long ready stall");
            end_errors++;
        end
        if (!settled) begin
            $display("A result was still pending at the end of the run");
            end_errors++;
        end
        $display("Summary: %0d frames, %0d results, %0d overruns, %0d errors",
                 frames_ended, results_seen, overruns_seen, error_count + end_errors);
        if (error_count == 0 && end_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    always @(posedge cclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/eye_pkg.sv
logic/camera_input.sv
logic/moment_accum.sv
logic/centroid_divider.sv
logic/eye_tracker_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_top
RTL_TOP   := eye_tracker_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

SOURCES := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
